/* rtl/i8080_pkg.sv */
`default_nettype none

package i8080_pkg;

    localparam int DATA_W = 8;

    typedef enum logic [2:0] {
        T1  = 3'd0,
        T2  = 3'd1,
        T3  = 3'd2,
        T4  = 3'd3,
        T5  = 3'd4,
        TR  = 3'd5, // held in reset
        TW  = 3'd6, // ready wait
        TWH = 3'd7  // halt wait
    } tstate_t;

    typedef enum logic [2:0] {
        M1 = 3'd0,
        M2 = 3'd1,
        M3 = 3'd2,
        M4 = 3'd3
    } mcycle_t;

    typedef enum logic [3:0] {
        cls_nop    = 4'd0,
        cls_ei     = 4'd1,
        cls_di     = 4'd2,
        cls_mov_rr = 4'd3,
        cls_mov_rm = 4'd4, // MOV r,M
        cls_mov_mr = 4'd5, // MOV M,r
        cls_mvi_r  = 4'd6,
        cls_mvi_m  = 4'd7,
        cls_lxi    = 4'd8,
        cls_lda    = 4'd9,
        cls_sta    = 4'd10,
        cls_jmp    = 4'd11,
        cls_hlt    = 4'd12
    } instr_class_t;

    // status word bits
    localparam int STATUS_INTA = 0;
    localparam int STATUS_WO_N = 1;
    localparam int STATUS_HLTA = 3;
    localparam int STATUS_M1   = 5;
    localparam int STATUS_MEMR = 7;

    // machine cycle kinds, sequencer to bus unit
    localparam logic [1:0] KIND_FETCH = 2'd0;
    localparam logic [1:0] KIND_READ  = 2'd1;
    localparam logic [1:0] KIND_WRITE = 2'd2;
    localparam logic [1:0] KIND_HALT  = 2'd3;

    localparam logic [DATA_W-1:0] OPC_NOP = 8'h00;
    localparam logic [DATA_W-1:0] OPC_HLT = 8'h76;
    localparam logic [DATA_W-1:0] OPC_EI  = 8'hfb;
    localparam logic [DATA_W-1:0] OPC_DI  = 8'hf3;
    localparam logic [DATA_W-1:0] OPC_LDA = 8'h3a;
    localparam logic [DATA_W-1:0] OPC_STA = 8'h32;
    localparam logic [DATA_W-1:0] OPC_JMP = 8'hc3;

    localparam logic [2:0] MEM_OPERAND = 3'd6; // register code M

    // opcode field patterns
    localparam logic [1:0] GRP_MOV  = 2'b01;    // 01dddsss
    localparam logic [1:0] GRP_LOW  = 2'b00;    // MVI and LXI live here
    localparam logic [2:0] MVI_TAIL = 3'b110;   // 00ddd110
    localparam logic [3:0] LXI_TAIL = 4'b0001;  // 00rp0001

endpackage

`default_nettype wire

/* rtl/opcode_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module opcode_decoder
    import i8080_pkg::*;
(
    input  logic              clk,
    input  logic              is_rst,
    input  logic [DATA_W-1:0] data_in,
    input  logic              fetch,
    output instr_class_t      instr_class,
    output logic              is_mem_dst
);

    logic [DATA_W-1:0] opcode_q;
    logic [2:0]        ddd;
    logic [2:0]        sss;
    logic [1:0]        grp;

    always_ff @(posedge clk) begin
        if (is_rst) begin
            opcode_q <= OPC_NOP;
        end else if (fetch) begin
            opcode_q <= data_in; // last T2/TW of M1
        end
    end

    assign grp = opcode_q[7:6];
    assign ddd = opcode_q[5:3];
    assign sss = opcode_q[2:0];

    always_comb begin
        instr_class = cls_nop;
        is_mem_dst  = 1'b0;

        if (opcode_q == OPC_HLT) begin
            instr_class = cls_hlt; // would be MOV M,M
        end else if (grp == GRP_MOV) begin
            if (ddd == MEM_OPERAND) begin
                instr_class = cls_mov_mr;
                is_mem_dst  = 1'b1;
            end else if (sss == MEM_OPERAND) begin
                instr_class = cls_mov_rm;
            end else begin
                instr_class = cls_mov_rr;
            end
        end else if (grp == GRP_LOW && sss == MVI_TAIL) begin
            if (ddd == MEM_OPERAND) begin
                instr_class = cls_mvi_m;
                is_mem_dst  = 1'b1;
            end else begin
                instr_class = cls_mvi_r;
            end
        end else if (grp == GRP_LOW && opcode_q[3:0] == LXI_TAIL) begin
            instr_class = cls_lxi;
        end else begin
            case (opcode_q)
                OPC_EI: begin
                    instr_class = cls_ei;
                end
                OPC_DI: begin
                    instr_class = cls_di;
                end
                OPC_LDA: begin
                    instr_class = cls_lda;
                end
                OPC_STA: begin
                    instr_class = cls_sta;
                end
                OPC_JMP: begin
                    instr_class = cls_jmp;
                end
                default: begin
                    instr_class = cls_nop; // everything else runs as NOP
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/interrupt_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module interrupt_ctrl
    import i8080_pkg::*;
(
    input  logic         clk,
    input  logic         is_rst,
    input  logic         intr,
    input  instr_class_t instr_class,
    input  logic         class_valid,
    input  logic         ack,
    output logic         inte,
    output logic         int_pending
);

    logic intr_prev;
    logic intr_rise;

    // only edges seen while enabled count
    assign intr_rise = intr & ~intr_prev & inte;

    always_ff @(posedge clk) begin
        if (is_rst) begin
            intr_prev   <= 1'b0;
            inte        <= 1'b0;
            int_pending <= 1'b0;
        end else begin
            intr_prev <= intr;

            if (class_valid && instr_class == cls_ei) begin
                inte <= 1'b1;
            end else if (class_valid && instr_class == cls_di) begin
                inte <= 1'b0;
            end

            // a new edge on the ack clock stays pending
            int_pending <= (int_pending & ~ack) | intr_rise;
        end
    end

endmodule

`default_nettype wire

/* rtl/cycle_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module cycle_sequencer
    import i8080_pkg::*;
(
    input  logic         clk,
    input  logic         is_rst,
    input  logic         ready,
    input  instr_class_t instr_class,
    input  logic         is_mem_dst,
    input  logic         int_pending,
    output logic         fetch,
    output logic         class_valid,
    output logic         ack,
    output logic         new_cycle,
    output logic         inta_next,
    output tstate_t      tstate,
    output logic [1:0]   kind
);

    mcycle_t mcycle;
    mcycle_t mcycle_nx;
    mcycle_t last_mcycle;
    tstate_t tstate_nx;
    logic    mcycle_end;
    logic    instr_end;
    logic    in_bus_state;
    logic    halt_cycle;

    always_comb begin
        case (instr_class)
            cls_mov_rm, cls_mov_mr, cls_mvi_r, cls_hlt: begin
                last_mcycle = M2;
            end
            cls_mvi_m, cls_lxi, cls_jmp: begin
                last_mcycle = M3;
            end
            cls_lda, cls_sta: begin
                last_mcycle = M4;
            end
            default: begin
                last_mcycle = M1; // fetch only
            end
        endcase
    end

    assign in_bus_state = (tstate == T2) || (tstate == TW);
    assign halt_cycle   = (instr_class == cls_hlt) && (mcycle == M2);

    always_comb begin
        mcycle_end = 1'b0;
        instr_end  = 1'b0;
        tstate_nx  = tstate;
        mcycle_nx  = mcycle;

        case (tstate)
            TR: begin
                instr_end = 1'b1; // first fetch after reset
            end
            T1: begin
                tstate_nx = T2;
            end
            T2, TW: begin
                if (halt_cycle) begin
                    tstate_nx = TWH;
                end else if (!ready) begin
                    tstate_nx = TW;
                end else begin
                    tstate_nx = T3;
                end
            end
            T3: begin
                if (mcycle == M1) begin
                    tstate_nx = T4;
                end else if (mcycle == last_mcycle) begin
                    instr_end = 1'b1;
                end else begin
                    mcycle_end = 1'b1;
                end
            end
            T4: begin
                if (instr_class == cls_mov_rr) begin
                    tstate_nx = T5;
                end else if (last_mcycle == M1) begin
                    instr_end = 1'b1;
                end else begin
                    mcycle_end = 1'b1;
                end
            end
            T5: begin
                instr_end = 1'b1;
            end
            TWH: begin
                instr_end = int_pending; // wake only on interrupt
            end
            default: begin
                instr_end = 1'b1;
            end
        endcase

        if (instr_end) begin
            tstate_nx = T1;
            mcycle_nx = M1;
        end else if (mcycle_end) begin
            tstate_nx = T1;
            mcycle_nx = mcycle_t'(mcycle + 3'd1);
        end
    end

    // kind of the cycle that starts on new_cycle
    always_comb begin
        if (instr_end) begin
            kind = KIND_FETCH;
        end else if (instr_class == cls_hlt && mcycle_nx == M2) begin
            kind = KIND_HALT;
        end else if (mcycle_nx == last_mcycle && (is_mem_dst || instr_class == cls_sta)) begin
            kind = KIND_WRITE;
        end else begin
            kind = KIND_READ;
        end
    end

    always_ff @(posedge clk) begin
        if (is_rst) begin
            tstate <= TR;
            mcycle <= M1;
        end else begin
            tstate <= tstate_nx;
            mcycle <= mcycle_nx;
        end
    end

    assign fetch       = (mcycle == M1) && in_bus_state && ready;
    assign class_valid = (mcycle == M1) && (tstate == T3);
    assign ack         = instr_end & int_pending;
    assign inta_next   = ack;
    assign new_cycle   = instr_end | mcycle_end;

endmodule

`default_nettype wire

/* rtl/bus_status.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_status
    import i8080_pkg::*;
(
    input  logic              clk,
    input  logic              is_rst,
    input  tstate_t           tstate,
    input  logic [1:0]        kind,
    input  logic              new_cycle,
    input  logic              inta_next,
    output logic              sync,
    output logic              dbin,
    output logic              write,
    output logic              wwait,
    output logic [DATA_W-1:0] status
);

    logic [1:0]        kind_q;
    logic [DATA_W-1:0] status_nx;
    logic              in_bus_state;
    logic              is_input;

    always_comb begin
        status_nx = '0;
        status_nx[STATUS_M1]   = (kind == KIND_FETCH);
        status_nx[STATUS_MEMR] = (kind == KIND_FETCH) || (kind == KIND_READ);
        status_nx[STATUS_WO_N] = (kind != KIND_WRITE);
        status_nx[STATUS_HLTA] = (kind == KIND_HALT);
        status_nx[STATUS_INTA] = (kind == KIND_FETCH) && inta_next;
    end

    // status holds for the whole machine cycle
    always_ff @(posedge clk) begin
        if (is_rst) begin
            kind_q <= KIND_FETCH;
            status <= '0;
        end else if (new_cycle) begin
            kind_q <= kind;
            status <= status_nx;
        end
    end

    assign in_bus_state = (tstate == T2) || (tstate == TW);
    assign is_input     = (kind_q == KIND_FETCH) || (kind_q == KIND_READ);

    assign sync  = (tstate == T1);
    assign dbin  = in_bus_state && is_input;
    assign write = in_bus_state && (kind_q == KIND_WRITE); // halt cycle drives neither
    assign wwait = (tstate == TW) || (tstate == TWH);

endmodule

`default_nettype wire

/* rtl/i8080_timing_top.sv */
`default_nettype none
`timescale 1ns/1ps

module i8080_timing_top
    import i8080_pkg::*;
(
    input  logic              clk,
    input  logic              is_rst,
    input  logic              ready,
    input  logic              intr,
    input  logic [DATA_W-1:0] data_in,
    output logic              sync,
    output logic              dbin,
    output logic              write,
    output logic              wwait,
    output logic              inte,
    output logic [DATA_W-1:0] status
);

    instr_class_t instr_class;
    tstate_t      tstate;
    logic [1:0]   kind;
    logic         is_mem_dst;
    logic         fetch;
    logic         class_valid;
    logic         ack;
    logic         new_cycle;
    logic         inta_next;
    logic         int_pending;

    opcode_decoder u_decoder (
        .clk         (clk),
        .is_rst      (is_rst),
        .data_in     (data_in),
        .fetch       (fetch),
        .instr_class (instr_class),
        .is_mem_dst  (is_mem_dst)
    );

    interrupt_ctrl u_int_ctrl (
        .clk         (clk),
        .is_rst      (is_rst),
        .intr        (intr),
        .instr_class (instr_class),
        .class_valid (class_valid),
        .ack         (ack),
        .inte        (inte),
        .int_pending (int_pending)
    );

    cycle_sequencer u_sequencer (
        .clk         (clk),
        .is_rst      (is_rst),
        .ready       (ready),
        .instr_class (instr_class),
        .is_mem_dst  (is_mem_dst),
        .int_pending (int_pending),
        .fetch       (fetch),
        .class_valid (class_valid),
        .ack         (ack),
        .new_cycle   (new_cycle),
        .inta_next   (inta_next),
        .tstate      (tstate),
        .kind        (kind)
    );

    bus_status u_bus_status (
        .clk       (clk),
        .is_rst    (is_rst),
        .tstate    (tstate),
        .kind      (kind),
        .new_cycle (new_cycle),
        .inta_next (inta_next),
        .sync      (sync),
        .dbin      (dbin),
        .write     (write),
        .wwait     (wwait),
        .status    (status)
    );

endmodule

`default_nettype wire

/* dv/bus_cycle_ref.svh */
`ifndef BUS_CYCLE_REF_SVH
`define BUS_CYCLE_REF_SVH

localparam logic [1:0] K_FETCH = 2'd0;
localparam logic [1:0] K_READ  = 2'd1;
localparam logic [1:0] K_WRITE = 2'd2;
localparam logic [1:0] K_HALT  = 2'd3;

// machine cycles of one instruction, returns the cycle count
function automatic int expected_cycles(input logic [7:0] opc, output logic [1:0] kinds [4],
                                       output int lens [4]);
    int n;
    for (int i = 0; i < 4; i++) begin
        kinds[i] = K_READ;
        lens[i]  = 3;
    end
    kinds[0] = K_FETCH;
    lens[0]  = 4;
    n        = 1;
    if (opc == OPC_HLT) begin
        kinds[1] = K_HALT;
        lens[1]  = 2; // T1 T2, then TWH counted as waits
        n        = 2;
    end else if (opc[7:6] == 2'b01) begin
        if (opc[5:3] == MEM_OPERAND) begin
            kinds[1] = K_WRITE;
            n        = 2;
        end else if (opc[2:0] == MEM_OPERAND) begin
            n = 2;
        end else begin
            lens[0] = 5; // register move adds T5
        end
    end else if (opc[7:6] == 2'b00 && opc[2:0] == 3'b110) begin
        n = 2;
        if (opc[5:3] == MEM_OPERAND) begin
            kinds[2] = K_WRITE;
            n        = 3;
        end
    end else if ((opc[7:6] == 2'b00 && opc[3:0] == 4'b0001) || opc == OPC_JMP) begin
        n = 3;
    end else if (opc == OPC_LDA) begin
        n = 4;
    end else if (opc == OPC_STA) begin
        kinds[3] = K_WRITE;
        n        = 4;
    end
    return n;
endfunction

function automatic logic [7:0] status_of(input logic [1:0] kind, input bit inta);
    logic [7:0] s;
    s = '0;
    s[STATUS_M1]   = (kind == K_FETCH);
    s[STATUS_MEMR] = (kind == K_FETCH) || (kind == K_READ);
    s[STATUS_WO_N] = (kind != K_WRITE);
    s[STATUS_HLTA] = (kind == K_HALT);
    s[STATUS_INTA] = (kind == K_FETCH) && inta;
    return s;
endfunction

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// any kept opcode except HLT
function automatic logic [7:0] random_kept_opcode();
    logic [31:0] r;
    logic [2:0]  d;
    logic [2:0]  s;
    r = next_rand();
    d = (r[26:24] == MEM_OPERAND) ? 3'd7 : r[26:24];
    s = (r[22:20] == MEM_OPERAND) ? 3'd0 : r[22:20];
    case (r[31:28] % 12)
        0: return OPC_NOP;
        1: return OPC_EI;
        2: return OPC_DI;
        3: return {2'b01, d, s};
        4: return {2'b01, d, MEM_OPERAND};
        5: return {2'b01, MEM_OPERAND, s};
        6: return {2'b00, d, 3'b110};
        7: return {2'b00, MEM_OPERAND, 3'b110};
        8: return {2'b00, r[19:18], 4'b0001};
        9: return OPC_LDA;
        10: return OPC_STA;
        default: return OPC_JMP;
    endcase
endfunction

`endif

/* dv/tb_i8080_timing.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_i8080_timing
    import i8080_pkg::*;
;
    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 4;
    localparam int N_RAND     = 300;
    localparam int N_WAIT     = 200;
    localparam int MAX_WAIT   = 3; // longest run of low ready
    localparam int HALT_HOLD  = 12;
    localparam int WORST_CLKS = (N_RAND + N_WAIT + 40) * 4 * (5 + MAX_WAIT)
                                + 5 * (RST_CYCLES + 8) + HALT_HOLD + 20;

    logic clk = 1'b0;
    logic is_rst, intr;
    logic ready = 1'b1;
    logic [7:0] data_in = 8'h00;
    logic sync, dbin, write, wwait, inte;
    logic [7:0] status;

    logic [31:0] lcg_state = 32'h1c25_2518;
    logic [7:0] stream[$];
    logic [7:0] exp_status[$], obs_status[$];
    int exp_len[$], obs_len[$], obs_waits[$], obs_exp_waits[$];
    logic exp_inte[$], obs_inte[$], obs_ok[$];
    int sidx;
    int low_run;
    int cmp_idx;
    int sync_count;
    int error_count = 0;
    int rec_len, rec_waits, rec_exp_waits, wake_at;
    logic [7:0] rec_status;
    logic rec_inte, rec_ok, in_rec;
    logic consume;
    logic wait_mode = 1'b0;
    logic model_inte;
    logic [7:0] o_st;
    logic o_inte, o_ok;
    int o_len, o_waits, o_exp_waits;
    logic [31:0] rnd;
    string cur_test = "reset";

    `include "bus_cycle_ref.svh"

    i8080_timing_top u_dut (.clk(clk), .is_rst(is_rst), .ready(ready), .intr(intr),
        .data_in(data_in), .sync(sync), .dbin(dbin), .write(write), .wwait(wwait),
        .inte(inte), .status(status));

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // bytes in stream order with NOP fill past the end
    always @(posedge clk) begin
        if (is_rst) begin
            sidx    = 0;
            low_run = 0;
        end else if (consume) begin
            sidx = sidx + 1;
        end
        data_in <= (sidx < stream.size()) ? stream[sidx] : OPC_NOP;
        if (wait_mode && !is_rst) begin
            rnd = next_rand();
            if (low_run < MAX_WAIT && rnd[31:30] == 2'b00) begin
                ready <= 1'b0;
                low_run++;
            end else begin
                ready   <= 1'b1;
                low_run = 0;
            end
        end else begin
            ready <= 1'b1;
        end
    end

    // one record per machine cycle up to the next sync
    always @(negedge clk) begin
        if (is_rst) begin
            in_rec     = 1'b0;
            consume    = 1'b0;
            sync_count = 0;
        end else begin
            if (sync) begin
                if (in_rec) begin
                    obs_status.push_back(rec_status);
                    obs_len.push_back(rec_len);
                    obs_waits.push_back(rec_waits);
                    obs_exp_waits.push_back(rec_exp_waits);
                    obs_inte.push_back(rec_inte);
                    obs_ok.push_back(rec_ok);
                end
                in_rec        = 1'b1;
                rec_len       = 0;
                rec_waits     = 0;
                rec_exp_waits = 0;
                wake_at       = 0;
                rec_status    = status;
                rec_inte      = inte;
                rec_ok        = 1'b1;
                sync_count++;
            end
            if (in_rec) begin
                rec_len++;
                if (rec_status[STATUS_HLTA]) begin
                    if (intr && wake_at == 0) begin
                        wake_at = rec_len;
                    end
                    // TWH ends two clocks after intr is first seen
                    if (rec_len > 2 && (wake_at == 0 || rec_len <= wake_at + 1)) begin
                        rec_exp_waits++;
                    end
                end else if (rec_len == 2 + rec_exp_waits && !ready) begin
                    rec_exp_waits++; // low ready in T2 or TW
                end
                if (wwait) begin
                    rec_waits++;
                    if (!rec_status[STATUS_HLTA] && !(dbin || write)) begin
                        rec_ok = 1'b0;
                    end
                end
                if (status !== rec_status) begin
                    rec_ok = 1'b0;
                end
            end
            consume = dbin && ready;
        end
    end

    always @(posedge clk) begin
        if (is_rst) begin
            obs_status.delete();
            obs_len.delete();
            obs_waits.delete();
            obs_exp_waits.delete();
            obs_inte.delete();
            obs_ok.delete();
            cmp_idx = 0;
        end else begin
            while (obs_status.size() > 0) begin
                o_st        = obs_status.pop_front();
                o_len       = obs_len.pop_front();
                o_waits     = obs_waits.pop_front();
                o_exp_waits = obs_exp_waits.pop_front();
                o_inte      = obs_inte.pop_front();
                o_ok        = obs_ok.pop_front();
                if (cmp_idx < exp_status.size()) begin // trailing NOP fill is ignored
                    check_value({cur_test, " status"}, exp_status[cmp_idx], o_st);
                    check_value({cur_test, " inte"}, exp_inte[cmp_idx], o_inte);
                    check_value({cur_test, " waits"}, o_exp_waits, o_waits);
                    check_value({cur_test, " clocks"}, exp_len[cmp_idx] + o_exp_waits, o_len);
                    check_value({cur_test, " strobes held"}, 1, o_ok);
                    cmp_idx++;
                end
            end
        end
    end

    task automatic append_instr(input logic [7:0] opc, input bit inta);
        logic [1:0]  kinds [4];
        int          lens [4];
        int          n;
        logic        after;
        logic [31:0] r;
        n     = expected_cycles(opc, kinds, lens);
        after = (opc == OPC_EI) ? 1'b1 : (opc == OPC_DI) ? 1'b0 : model_inte;
        stream.push_back(opc);
        for (int i = 0; i < n; i++) begin
            exp_status.push_back(status_of(kinds[i], inta && i == 0));
            exp_len.push_back(lens[i]);
            exp_inte.push_back(i == 0 ? model_inte : after); // EI and DI act at T3 of M1
            if (i > 0 && kinds[i] == K_READ) begin
                r = next_rand();
                stream.push_back(r[31:24]);
            end
        end
        model_inte = after;
    endtask

    task automatic check_idle(input string name);
        check_value({name, " sync"}, 0, sync);
        check_value({name, " dbin"}, 0, dbin);
        check_value({name, " write"}, 0, write);
        check_value({name, " wwait"}, 0, wwait);
        check_value({name, " inte"}, 0, inte);
        check_value({name, " status"}, 0, status);
    endtask

    task automatic start_reset(input string name);
        @(posedge clk);
        is_rst <= 1'b1;
        intr   <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        cur_test = name;
        check_idle({name, " in reset"});
        stream.delete();
        exp_status.delete();
        exp_len.delete();
        exp_inte.delete();
        model_inte = 1'b0;
    endtask

    task automatic release_reset();
        @(posedge clk);
        is_rst <= 1'b0;
        @(negedge clk);
        check_idle({cur_test, " after reset"});
        @(negedge clk);
        check_value({cur_test, " first sync"}, 1, sync);
    endtask

    task automatic wait_done();
        while (cmp_idx < exp_status.size()) @(negedge clk);
    endtask

    task automatic pulse_intr_at(input int rec);
        @(posedge clk);
        while (sync_count < rec) @(posedge clk);
        intr <= 1'b1;
        repeat (2) @(posedge clk);
        intr <= 1'b0;
    endtask

    initial begin
        #(2 * WORST_CLKS * CLK_PERIOD);
        $display("TIMEOUT: the expected bus cycles did not all appear in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        is_rst = 1'b1;
        intr   = 1'b0;
        start_reset("reset");
        append_instr(OPC_NOP, 1'b0);
        append_instr(OPC_NOP, 1'b0);
        release_reset();
        wait_done();

        start_reset("ready_high");
        for (int i = 0; i < N_RAND; i++) append_instr(random_kept_opcode(), 1'b0);
        release_reset();
        wait_done();

        start_reset("wait_states");
        for (int i = 0; i < N_WAIT; i++) append_instr(random_kept_opcode(), 1'b0);
        wait_mode = 1'b1;
        release_reset();
        wait_done();
        wait_mode = 1'b0;

        start_reset("halt_wake");
        append_instr(OPC_EI, 1'b0);
        append_instr(OPC_HLT, 1'b0);
        append_instr(OPC_NOP, 1'b1); // acknowledge fetch
        append_instr(OPC_NOP, 1'b0);
        release_reset();
        while (sync_count < 3) @(posedge clk);
        @(negedge clk);
        repeat (HALT_HOLD) begin
            @(negedge clk);
            check_value("halt_wake wwait", 1, wwait);
        end
        pulse_intr_at(3);
        wait_done();

        start_reset("int_enable");
        append_instr(OPC_NOP, 1'b0);
        append_instr(OPC_LDA, 1'b0); // edge here is ignored while inte is low
        append_instr(OPC_NOP, 1'b0);
        append_instr(OPC_EI, 1'b0);
        append_instr(OPC_NOP, 1'b0);
        append_instr(OPC_LDA, 1'b0);
        append_instr(OPC_NOP, 1'b1);
        append_instr(OPC_NOP, 1'b0);
        append_instr(OPC_DI, 1'b0);
        append_instr(OPC_NOP, 1'b0);
        release_reset();
        pulse_intr_at(2);
        pulse_intr_at(9);
        wait_done();

        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+dv
rtl/i8080_pkg.sv
rtl/opcode_decoder.sv
rtl/interrupt_ctrl.sv
rtl/cycle_sequencer.sv
rtl/bus_status.sv
rtl/i8080_timing_top.sv
dv/tb_i8080_timing.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_i8080_timing -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation completed successfully" sim.log
